// ==== pcs_pkg.sv ====
package pcs_pkg;

    // ##################################################
    // Block widths
    // ##################################################

    // One 64b/66b coded block, sync header included
    localparam int LEN_CODED_BLOCK  = 66;

    // Alignment tag goes on top of the coded block
    localparam int LEN_TAGGED_BLOCK = LEN_CODED_BLOCK + 1;

    // ##################################################
    // Lane gathering
    // ##################################################

    localparam int N_LANES     = 20;                          // PCS lanes per wide word
    localparam int NB_DATA_BUS = LEN_TAGGED_BLOCK * N_LANES;  // Wide word width
    localparam int NB_INDEX    = $clog2(N_LANES);             // Lane index width

    // ##################################################
    // Alignment period
    // ##################################################

    // Coded blocks between two alignment boundaries. A multiple of
    // N_LANES, so a tagged block always lands in lane 0 of its word
    localparam int AM_PERIOD_BLOCKS = 4 * N_LANES;

    localparam int NB_AM_COUNT = $clog2(AM_PERIOD_BLOCKS);    // Period counter width

endpackage

// ==== block_tagger.sv ====
module block_tagger
    import pcs_pkg::*;
(
    input  logic                          i_clock,
    input  logic                          i_reset,
    input  logic                          i_enable,
    input  logic                          i_valid,
    input  logic [LEN_CODED_BLOCK-1:0]    i_data,

    output logic                          o_valid,
    output logic [LEN_TAGGED_BLOCK-1:0]   o_data
);

    logic [NB_AM_COUNT-1:0] am_count;   // Position inside the alignment period
    logic                   accept;
    logic                   period_end;

    assign accept     = i_enable && i_valid;
    assign period_end = (am_count == NB_AM_COUNT'(AM_PERIOD_BLOCKS - 1));

    // ##################################################
    // Period counter and valid
    // ##################################################

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            am_count <= '0;
            o_valid  <= 1'b0;
        end
        else if (i_enable)                  // Whole stage frozen otherwise
        begin
            o_valid <= i_valid;
            if (i_valid)
            begin
                if (period_end)
                    am_count <= '0;
                else
                    am_count <= am_count + 1'b1;
            end
        end
    end

    // Tag marks the first block of each period
    always_ff @(posedge i_clock)
    begin
        if (accept)
            o_data <= {(am_count == '0), i_data};
    end

endmodule

// ==== parallel_converter_1_to_n.sv ====
module parallel_converter_1_to_n
    import pcs_pkg::*;
(
    input  logic                          i_clock,
    input  logic                          i_reset,
    input  logic                          i_enable,
    input  logic                          i_valid,
    input  logic [LEN_TAGGED_BLOCK-1:0]   i_data,

    output logic                          o_valid,
    output logic [NB_DATA_BUS-1:0]        o_data
);

    logic [NB_INDEX-1:0]    index;          // Lane that takes the next block
    logic [NB_DATA_BUS-1:0] store_data;     // Partially gathered word
    logic                   accept;
    logic                   count_done;

    assign accept     = i_enable && i_valid;
    assign count_done = accept && (index == NB_INDEX'(N_LANES - 1));

    // ##################################################
    // Lane index
    // ##################################################

    // Wraps to zero on the last block, no idle cycle between words
    always_ff @(posedge i_clock)
    begin
        if (i_reset || count_done)
            index <= '0;
        else if (accept)
            index <= index + 1'b1;
    end

    // Lane 0 is the top slice, later lanes fill downward
    always_ff @(posedge i_clock)
    begin
        if (accept)
        begin
            store_data[NB_DATA_BUS - 1 - LEN_TAGGED_BLOCK * int'(index) -: LEN_TAGGED_BLOCK]
                <= i_data;
        end
    end

    // ##################################################
    // Output word
    // ##################################################

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            o_valid <= 1'b0;
        else if (i_enable)
            o_valid <= count_done;      // Held through frozen cycles
    end

    // Last block goes straight into the word, the store only has lanes above it
    always_ff @(posedge i_clock)
    begin
        if (count_done)
            o_data <= {store_data[NB_DATA_BUS-1:LEN_TAGGED_BLOCK], i_data};
    end

    a_index_in_range : assert property (
        @(posedge i_clock) disable iff (i_reset)
        index <= NB_INDEX'(N_LANES - 1)
    ) else $error("parallel_converter_1_to_n: lane index %0d out of range", index);

endmodule

// ==== lane_parity_accumulator.sv ====
module lane_parity_accumulator
    import pcs_pkg::*;
(
    input  logic                        i_clock,
    input  logic                        i_reset,
    input  logic                        i_enable,
    input  logic                        i_valid,
    input  logic [NB_DATA_BUS-1:0]      i_data,

    output logic                        o_bip_valid,
    output logic [N_LANES-1:0]          o_bip          // Bit n is lane n
);

    logic [N_LANES-1:0] lane_parity;    // Even parity of each lane's coded bits
    logic [N_LANES-1:0] lane_tag;       // Tag bit of each lane
    logic [N_LANES-1:0] acc_parity;     // Running parity of the current period
    logic               have_period;    // A full period is behind us
    logic               accept;
    logic               boundary;

    assign accept   = i_enable && i_valid;
    assign boundary = accept && lane_tag[0];

    // Split the wide word, lane 0 at the top
    always_comb
    begin
        for (int lane = 0; lane < N_LANES; lane++)
        begin
            lane_tag[lane]    = i_data[NB_DATA_BUS - 1 - LEN_TAGGED_BLOCK * lane];
            lane_parity[lane] =
                ^i_data[NB_DATA_BUS - 2 - LEN_TAGGED_BLOCK * lane -: LEN_CODED_BLOCK];
        end
    end

    // ##################################################
    // Accumulation
    // ##################################################

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            acc_parity  <= '0;
            have_period <= 1'b0;
            o_bip_valid <= 1'b0;
        end
        else if (i_enable)
        begin
            o_bip_valid <= boundary && have_period;  // Nothing to report on the first one
            if (boundary)
            begin
                acc_parity  <= lane_parity;          // New period starts with this word
                have_period <= 1'b1;
            end
            else if (i_valid)
                acc_parity <= acc_parity ^ lane_parity;
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (boundary)
            o_bip <= acc_parity;
    end

    // The period length is a multiple of the lane count upstream
    a_tag_lane0_only : assert property (
        @(posedge i_clock) disable iff (i_reset)
        accept |-> (lane_tag[N_LANES-1:1] == '0)
    ) else $error("lane_parity_accumulator: tag bit set outside lane 0");

endmodule

// ==== pcs_lane_gather_top.sv ====
module pcs_lane_gather_top
    import pcs_pkg::*;
(
    input  logic                          i_clock,
    input  logic                          i_reset,
    input  logic                          i_enable,
    input  logic                          i_valid,
    input  logic [LEN_CODED_BLOCK-1:0]    i_data,

    output logic                          o_valid,
    output logic [NB_DATA_BUS-1:0]        o_data,
    output logic                          o_bip_valid,
    output logic [N_LANES-1:0]            o_bip
);

    // ##################################################
    // Inter-stage wires
    // ##################################################

    logic                         tagged_valid;
    logic [LEN_TAGGED_BLOCK-1:0]  tagged_data;   // Tag in the MSB
    logic                         word_valid;
    logic [NB_DATA_BUS-1:0]       word_data;

    assign o_valid = word_valid;
    assign o_data  = word_data;

    block_tagger u_block_tagger (
        .i_clock  (i_clock),
        .i_reset  (i_reset),
        .i_enable (i_enable),
        .i_valid  (i_valid),
        .i_data   (i_data),
        .o_valid  (tagged_valid),
        .o_data   (tagged_data)
    );

    parallel_converter_1_to_n u_parallel_converter (
        .i_clock  (i_clock),
        .i_reset  (i_reset),
        .i_enable (i_enable),
        .i_valid  (tagged_valid),
        .i_data   (tagged_data),
        .o_valid  (word_valid),
        .o_data   (word_data)
    );

    // Lane BIP over each alignment period
    lane_parity_accumulator u_lane_parity_accumulator (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_enable    (i_enable),
        .i_valid     (word_valid),
        .i_data      (word_data),
        .o_bip_valid (o_bip_valid),
        .o_bip       (o_bip)
    );

endmodule

// ==== tb_pcs_lane_gather.sv ====
module tb_pcs_lane_gather
    import pcs_pkg::*;
;

    localparam int CLOCK_PERIOD    = 20;
    localparam int RESET_CYCLES    = 8;
    localparam int MIN_WORDS       = 12;                       // Three full alignment periods
    localparam int TARGET_BLOCKS   = 14 * N_LANES + 7;         // Ends on a partial word
    localparam int DRAIN_CYCLES    = 12;
    localparam int WATCHDOG_CYCLES = 30 * MIN_WORDS * N_LANES;

    logic                       i_clock = 1'b0;
    logic                       i_reset;
    logic                       i_enable;
    logic                       i_valid;
    logic [LEN_CODED_BLOCK-1:0] i_data;
    logic                       o_valid;
    logic [NB_DATA_BUS-1:0]     o_data;
    logic                       o_bip_valid;
    logic [N_LANES-1:0]         o_bip;

    int seed = 32'h7300;
    int errors = 0;
    int freeze_left = 0;                                       // Cycles left in an enable-low burst

    // Reference model state
    int                     blocks_accepted;
    logic [NB_DATA_BUS-1:0] gather_word;
    logic [N_LANES-1:0]     gather_par;
    logic [N_LANES-1:0]     period_par;
    logic                   have_period;
    logic [NB_DATA_BUS-1:0] exp_words [64];
    logic [N_LANES-1:0]     exp_bips [16];
    logic [5:0]             word_wr, word_rd;
    logic [3:0]             bip_wr, bip_rd;
    logic [NB_DATA_BUS-1:0] exp_word_head;
    logic [N_LANES-1:0]     exp_bip_head;
    logic                   word_pending, bip_pending;
    int                     words_seen, tagged_seen, bips_seen;
    logic                   reset_seen = 1'b0;

    pcs_lane_gather_top dut (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_enable    (i_enable),
        .i_valid     (i_valid),
        .i_data      (i_data),
        .o_valid     (o_valid),
        .o_data      (o_data),
        .o_bip_valid (o_bip_valid),
        .o_bip       (o_bip)
    );

    initial
    begin
        forever #(CLOCK_PERIOD / 2) i_clock = ~i_clock;
    end

    // ##################################################
    // Reference model
    // ##################################################

    always @(posedge i_clock)
    begin : reference_model
        logic                   tag;
        int                     lane;
        logic [NB_DATA_BUS-1:0] word_next;
        logic [N_LANES-1:0]     par_next;
        if (i_reset)
        begin
            blocks_accepted <= 0;
            gather_word     <= '0;
            gather_par      <= '0;
            period_par      <= '0;
            have_period     <= 1'b0;
            word_wr         <= '0;
            bip_wr          <= '0;
        end
        else if (i_enable && i_valid)
        begin
            tag       = (blocks_accepted % AM_PERIOD_BLOCKS) == 0;  // First block of a period
            lane      = blocks_accepted % N_LANES;
            word_next = {gather_word[NB_DATA_BUS-LEN_TAGGED_BLOCK-1:0], tag, i_data};
            par_next  = (lane == 0) ? '0 : gather_par;
            par_next  = par_next | (N_LANES'(^i_data) << lane);
            blocks_accepted <= blocks_accepted + 1;
            gather_word     <= word_next;
            gather_par      <= par_next;
            if (lane == N_LANES - 1)
            begin
                exp_words[word_wr] <= word_next;
                word_wr            <= word_wr + 1'b1;
                if (word_next[NB_DATA_BUS-1])              // Tagged word opens a new period
                begin
                    if (have_period)
                    begin
                        exp_bips[bip_wr] <= period_par;
                        bip_wr           <= bip_wr + 1'b1;
                    end
                    period_par  <= par_next;
                    have_period <= 1'b1;
                end
                else
                    period_par <= period_par ^ par_next;
            end
        end
    end

    assign exp_word_head = exp_words[word_rd];
    assign exp_bip_head  = exp_bips[bip_rd];
    assign word_pending  = (word_rd != word_wr);
    assign bip_pending   = (bip_rd != bip_wr);

    // Outputs count once, on the enabled cycle that consumes them
    always @(posedge i_clock)
    begin
        reset_seen <= i_reset;
        if (i_reset)
        begin
            word_rd     <= '0;
            bip_rd      <= '0;
            words_seen  <= 0;
            tagged_seen <= 0;
            bips_seen   <= 0;
        end
        else if (i_enable)
        begin
            if (o_valid)
            begin
                word_rd    <= word_rd + 1'b1;
                words_seen <= words_seen + 1;
                if (o_data[NB_DATA_BUS-1])
                    tagged_seen <= tagged_seen + 1;
            end
            if (o_bip_valid)
            begin
                bip_rd    <= bip_rd + 1'b1;
                bips_seen <= bips_seen + 1;
            end
        end
    end

    // ##################################################
    // Checks
    // ##################################################

    a_quiet_in_reset : assert property (
        @(posedge i_clock) (i_reset && reset_seen) |-> (!o_valid && !o_bip_valid)
    ) else
    begin
        errors++;
        $display("[FAIL] %0t: output valid high during reset", $time);
    end

    a_word_matches : assert property (
        @(posedge i_clock) disable iff (i_reset)
        (o_valid && i_enable) |-> (word_pending && o_data == exp_word_head)
    ) else
    begin
        errors++;
        $display("[FAIL] %0t: word %0d wrong or not expected yet", $time, words_seen);
    end

    a_bip_matches : assert property (
        @(posedge i_clock) disable iff (i_reset)
        (o_bip_valid && i_enable) |-> (bip_pending && o_bip == exp_bip_head)
    ) else
    begin
        errors++;
        $display("[FAIL] %0t: BIP %0d got %h, expected %h", $time, bips_seen, o_bip,
                 exp_bip_head);
    end

    a_bip_follows_tag : assert property (
        @(posedge i_clock) disable iff (i_reset)
        $rose(o_bip_valid) |-> $past(o_valid && i_enable && o_data[NB_DATA_BUS-1])
    ) else
    begin
        errors++;
        $display("[FAIL] %0t: BIP reported without a tagged word before it", $time);
    end

    // ##################################################
    // Stimulus
    // ##################################################

    task automatic drive_random_cycle();
        logic [31:0] r0, r1, r2;
        r0 = $random(seed);
        r1 = $random(seed);
        r2 = $random(seed);
        @(posedge i_clock);
        if (freeze_left > 0)
        begin
            i_enable    <= 1'b0;
            freeze_left = freeze_left - 1;
        end
        else
        begin
            i_enable <= 1'b1;
            if (r0[5:2] == 4'd0)
                freeze_left = 1 + int'(r0[7:6]);            // Burst of 1 to 4 frozen cycles
        end
        i_valid <= (r0[1:0] != 2'b00);
        i_data  <= {r0[31:30], r1, r2};
    endtask

    task automatic drain_pipeline();
        repeat (DRAIN_CYCLES)
        begin
            @(posedge i_clock);
            i_enable <= 1'b1;
            i_valid  <= 1'b0;
        end
    endtask

    task automatic check_totals();
        assert (words_seen == blocks_accepted / N_LANES)
        else
        begin
            errors++;
            $display("[FAIL] %0t: %0d words for %0d accepted blocks", $time, words_seen,
                     blocks_accepted);
        end
        assert (bips_seen == tagged_seen - 1 && !word_pending && !bip_pending)
        else
        begin
            errors++;
            $display("[FAIL] %0t: %0d BIP reports for %0d tagged words", $time, bips_seen,
                     tagged_seen);
        end
        assert (tagged_seen >= MIN_WORDS / 4 + 1)
        else
        begin
            errors++;
            $display("Stimulus ended before three full alignment periods were seen");
        end
    endtask

    initial
    begin
        i_reset  = 1'b1;
        i_enable = 1'b0;
        i_valid  = 1'b0;
        i_data   = '0;
        repeat (RESET_CYCLES) @(posedge i_clock);
        i_reset <= 1'b0;
        while (blocks_accepted < TARGET_BLOCKS)
            drive_random_cycle();
        drain_pipeline();
        @(negedge i_clock);                                    // Let the last counts settle
        check_totals();
        $display("Summary: %0d errors, %0d words, %0d tagged words, %0d BIP reports",
                 errors, words_seen, tagged_seen, bips_seen);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_CYCLES * CLOCK_PERIOD);
        $display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== tb.f ====
pcs_pkg.sv
block_tagger.sv
parallel_converter_1_to_n.sv
lane_parity_accumulator.sv
pcs_lane_gather_top.sv
tb_pcs_lane_gather.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_pcs_lane_gather
FILELIST = tb.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: simulate clean

# Pass or fail is taken from the log, not from the simulator exit code
simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
